// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/10ps
TOP       = codec_init_tb
FILELIST  = src.f
BUILD_DIR = obj_dir
PASS_MSG  = TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== cfg_table.sv ====
`timescale 1ns/10ps

module cfg_table (
    input  logic [codec_cfg_pkg::CMD_IDX_W-1:0] i_cmd_idx,
    output codec_cfg_pkg::cfg_frame_t           o_frame
);
    import codec_cfg_pkg::*;

    // power-up order, index 0 first
    localparam logic [6:0] REG_ADDR [N_CMDS] = '{
        7'h0F,  // reset
        7'h04,  // analog path
        7'h05,  // digital path
        7'h06,  // power down control
        7'h07,  // interface format
        7'h08,  // sampling control
        7'h09   // active
    };

    localparam logic [8:0] REG_DATA [N_CMDS] = '{
        9'h000,
        9'h015,
        9'h000,
        9'h000,
        9'h042,
        9'h019,
        9'h001
    };

    always_comb begin
        o_frame.fields.dev_addr = DEV_ADDR;
        o_frame.fields.rw       = 1'b0;
        if (i_cmd_idx < CMD_IDX_W'(N_CMDS)) begin
            o_frame.fields.reg_addr = REG_ADDR[i_cmd_idx];
            o_frame.fields.reg_data = REG_DATA[i_cmd_idx];
        end else begin
            o_frame.fields.reg_addr = '0;  // unused index
            o_frame.fields.reg_data = '0;
        end
    end

endmodule

// ==== codec_cfg_pkg.sv ====
package codec_cfg_pkg;

    localparam int FRAME_W     = 24;
    localparam int FRAME_BYTES = FRAME_W / 8;
    localparam int N_CMDS      = 7;
    localparam int CMD_IDX_W   = 3;

    localparam logic [6:0] DEV_ADDR = 7'h1A; // 0x34 on the wire with write bit

    typedef struct packed {
        logic [6:0] dev_addr;
        logic       rw;       // 0 = write
        logic [6:0] reg_addr;
        logic [8:0] reg_data;
    } cfg_fields_t;

    // same 24-bit command, seen as wire bytes or as codec fields
    typedef union packed {
        logic [FRAME_BYTES-1:0][7:0] bytes;  // bytes[FRAME_BYTES-1] goes out first
        cfg_fields_t                 fields;
    } cfg_frame_t;

    typedef enum logic [2:0] {
        IDLE,
        START,
        DATA,
        ACK,
        STOP,
        COOLDOWN
    } init_state_t;

endpackage

// ==== codec_init_tb.sv ====
`timescale 1ns/10ps

module codec_init_tb;

    localparam int CLK_DIV        = 4;
    localparam int MAX_RETRY      = 3;
    localparam int COOLDOWN_TICKS = 8;
    localparam int N_CMDS         = 7;
    localparam int N_RUNS         = 5;
    // 58 ticks per frame plus one spare command slot per run for retries
    localparam int MAX_CYCLES = N_RUNS * (N_CMDS + 1) * 60 * CLK_DIV
                              + N_RUNS * COOLDOWN_TICKS * CLK_DIV + 2000;

    localparam logic [6:0] EXP_REG [N_CMDS] = '{
        7'h0F, 7'h04, 7'h05, 7'h06, 7'h07, 7'h08, 7'h09
    };
    localparam logic [8:0] EXP_DATA [N_CMDS] = '{
        9'h000, 9'h015, 9'h000, 9'h000, 9'h042, 9'h019, 9'h001
    };

    logic        clk;
    logic        rst_n;
    logic        start;
    logic        sda_line;
    logic        scl;
    logic        sda_m;
    logic        sda_oe;
    logic        finished;
    logic        err_pulse;
    logic        busy;
    logic [6:0]  nack_reg;
    logic [7:0]  nack_count;
    logic        frame_valid;
    logic [23:0] frame_word;
    logic [23:0] popped;
    logic [23:0] frames_q [$];
    logic [31:0] rnd;
    int          proto_errs;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          exp_idx = 0;
    int          run_frames = 0;
    int          fin_cnt = 0;
    int          err_cnt = 0;

    tb_clk_gen #(
        .PERIOD_NS  (40),
        .RST_CYCLES (3)
    ) clk_src (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    codec_init_top #(
        .CLK_DIV        (CLK_DIV),
        .MAX_RETRY      (MAX_RETRY),
        .COOLDOWN_TICKS (COOLDOWN_TICKS)
    ) uut (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_start    (start),
        .i_sda      (sda_line),
        .o_scl      (scl),
        .o_sda      (sda_m),
        .o_sda_oe   (sda_oe),
        .o_finished (finished),
        .o_error    (err_pulse),
        .o_busy     (busy)
    );

    tb_i2c_slave slave (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_scl         (scl),
        .i_sda_m       (sda_m),
        .i_sda_oe      (sda_oe),
        .i_nack_reg    (nack_reg),
        .i_nack_count  (nack_count),
        .o_sda_line    (sda_line),
        .o_frame_valid (frame_valid),
        .o_frame       (frame_word),
        .o_err_cnt     (proto_errs)
    );

    // device 0x1A with write bit then register and 9-bit value
    function automatic logic [23:0] expected_frame(input int idx);
        if (idx < 0 || idx >= N_CMDS) begin
            return 24'hFFFFFF;
        end
        return {7'h1A, 1'b0, EXP_REG[idx], EXP_DATA[idx]};
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    always @(posedge clk) begin
        if (frame_valid) begin
            frames_q.push_back(frame_word);
        end
    end

    always @(negedge clk) begin
        while (frames_q.size() > 0) begin
            popped = frames_q.pop_front();
            check_value($sformatf("frame %0d", exp_idx), 32'(popped),
                        32'(expected_frame(exp_idx)));
            exp_idx++;
            run_frames++;
        end
        if (finished) fin_cnt++;
        if (err_pulse) err_cnt++;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the runs did not end within %0d cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic pulse_start();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic run_sequence(input string name, input logic [6:0] nreg,
                                input logic [7:0] ncount, input int exp_frames,
                                input int exp_fin, input int exp_err, input bit poke_busy);
        int gap;
        @(negedge clk);
        nack_reg   = nreg;
        nack_count = ncount;
        exp_idx    = 0;
        run_frames = 0;
        fin_cnt    = 0;
        err_cnt    = 0;
        rnd = lcg_next(rnd);
        gap = int'(rnd[19:16]) + 1;
        repeat (gap) @(negedge clk);
        pulse_start();
        check_value({name, " busy after start"}, 32'(busy), 32'd1);
        if (poke_busy) begin
            rnd = lcg_next(rnd);
            repeat (int'(rnd[25:18]) + 100) @(negedge clk);
            check_value({name, " busy before second start"}, 32'(busy), 32'd1);
            pulse_start();  // must be ignored
        end
        while (busy) @(negedge clk);
        repeat (4) @(negedge clk);
        check_value({name, " frame count"}, run_frames, exp_frames);
        check_value({name, " finished pulses"}, fin_cnt, exp_fin);
        check_value({name, " error pulses"}, err_cnt, exp_err);
        check_value({name, " scl idle"}, 32'(scl), 32'd1);
        check_value({name, " sda idle"}, 32'(sda_m), 32'd1);
    endtask

    initial begin
        start      = 1'b0;
        nack_reg   = 7'h00;
        nack_count = 8'd0;
        rnd        = 32'hd496b2c1;

        @(posedge rst_n);
        @(negedge clk);
        check_value("reset scl", 32'(scl), 32'd1);
        check_value("reset sda", 32'(sda_m), 32'd1);
        check_value("reset sda_oe", 32'(sda_oe), 32'd1);
        check_value("reset finished", 32'(finished), 32'd0);
        check_value("reset error", 32'(err_pulse), 32'd0);
        check_value("reset busy", 32'(busy), 32'd0);
        repeat (20) @(negedge clk);
        check_value("idle scl", 32'(scl), 32'd1);
        check_value("idle sda", 32'(sda_m), 32'd1);
        check_value("idle busy", 32'(busy), 32'd0);

        run_sequence("full", 7'h00, 8'd0, N_CMDS, 1, 0, 1'b0);
        run_sequence("start while busy", 7'h00, 8'd0, N_CMDS, 1, 0, 1'b1);
        run_sequence("restart", 7'h00, 8'd0, N_CMDS, 1, 0, 1'b0);
        run_sequence("retry", 7'h05, 8'd1, N_CMDS, 1, 0, 1'b0);
        run_sequence("give-up", 7'h07, 8'(MAX_RETRY), 4, 0, 1, 1'b0);

        $display("checks %0d, mismatches %0d, protocol errors %0d",
                 checks, errors, proto_errs);
        if (errors == 0 && proto_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== codec_init_top.sv ====
`timescale 1ns/10ps

module codec_init_top #(
    parameter int CLK_DIV        = 125,
    parameter int MAX_RETRY      = 3,
    parameter int COOLDOWN_TICKS = 8
) (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_start,
    input  logic i_sda,
    output logic o_scl,
    output logic o_sda,
    output logic o_sda_oe,
    output logic o_finished,
    output logic o_error,
    output logic o_busy
);
    import codec_cfg_pkg::*;

    logic                 tick;
    logic [CMD_IDX_W-1:0] cmd_idx;

    shift_if sif ();

    scl_tick_gen #(
        .CLK_DIV (CLK_DIV)
    ) u_tick (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_en    (o_busy),
        .o_tick  (tick)
    );

    cfg_table u_table (
        .i_cmd_idx (cmd_idx),
        .o_frame   (sif.frame)
    );

    frame_shifter u_shifter (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .sif     (sif.shifter)
    );

    init_ctrl #(
        .MAX_RETRY      (MAX_RETRY),
        .COOLDOWN_TICKS (COOLDOWN_TICKS)
    ) u_ctrl (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (i_start),
        .i_tick     (tick),
        .i_sda      (i_sda),
        .o_cmd_idx  (cmd_idx),
        .sif        (sif.ctrl),
        .o_scl      (o_scl),
        .o_sda      (o_sda),
        .o_sda_oe   (o_sda_oe),
        .o_finished (o_finished),
        .o_error    (o_error),
        .o_busy     (o_busy)
    );

endmodule

// ==== frame_shifter.sv ====
`timescale 1ns/10ps

module frame_shifter (
    input  logic     i_clk,
    input  logic     i_rst_n,
    shift_if.shifter sif
);
    import codec_cfg_pkg::*;

    localparam int CNT_W = $clog2(FRAME_W);

    cfg_frame_t       frame_r;
    logic [CNT_W-1:0] bit_cnt_r;

    // shift left one bit across the byte view, msb of each byte
    // carries into the byte above it
    always_ff @(posedge i_clk) begin
        if (sif.load) begin
            frame_r <= sif.frame;
        end else if (sif.shift) begin
            for (int i = FRAME_BYTES - 1; i > 0; i--) begin
                frame_r.bytes[i] <= {frame_r.bytes[i][6:0], frame_r.bytes[i-1][7]};
            end
            frame_r.bytes[0] <= {frame_r.bytes[0][6:0], 1'b0};
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bit_cnt_r <= '0;
        end else if (sif.load) begin
            bit_cnt_r <= '0;
        end else if (sif.shift) begin
            bit_cnt_r <= bit_cnt_r + 1'b1;
        end
    end

    assign sif.sda_bit   = frame_r.bytes[FRAME_BYTES-1][7];
    assign sif.byte_end  = &bit_cnt_r[2:0];  // bit 7 of a byte
    assign sif.frame_end = (bit_cnt_r == CNT_W'(FRAME_W - 1));

endmodule

// ==== init_ctrl.sv ====
`timescale 1ns/10ps

module init_ctrl #(
    parameter int MAX_RETRY      = 3,
    parameter int COOLDOWN_TICKS = 8
) (
    input  logic                               i_clk,
    input  logic                               i_rst_n,
    input  logic                               i_start,
    input  logic                               i_tick,
    input  logic                               i_sda,
    output logic [codec_cfg_pkg::CMD_IDX_W-1:0] o_cmd_idx,
    shift_if.ctrl                              sif,
    output logic                               o_scl,
    output logic                               o_sda,
    output logic                               o_sda_oe,
    output logic                               o_finished,
    output logic                               o_error,
    output logic                               o_busy
);
    import codec_cfg_pkg::*;

    localparam int RETRY_W = $clog2(MAX_RETRY + 1);
    localparam int COOL_W  = (COOLDOWN_TICKS > 1) ? $clog2(COOLDOWN_TICKS) : 1;

    init_state_t          state_r, state_w;
    logic                 scl_r, scl_w;
    logic                 sda_r, sda_w;
    logic                 oe_r, oe_w;
    logic                 finished_r, finished_w;
    logic                 error_r, error_w;
    logic                 last_r, last_w;       // bit or byte just sent ends its unit
    logic [CMD_IDX_W-1:0] cmd_idx_r, cmd_idx_w;
    logic [RETRY_W-1:0]   retry_r, retry_w;     // consecutive nacks on this cmd
    logic [COOL_W-1:0]    cool_r, cool_w;
    logic [1:0]           sda_sync_r;

    assign o_cmd_idx  = cmd_idx_r;
    assign o_scl      = scl_r;
    assign o_sda      = sda_r;
    assign o_sda_oe   = oe_r;
    assign o_finished = finished_r;
    assign o_error    = error_r;
    assign o_busy     = (state_r != IDLE);

    always_comb begin
        state_w    = state_r;
        scl_w      = scl_r;
        sda_w      = sda_r;
        oe_w       = oe_r;
        finished_w = 1'b0;
        error_w    = 1'b0;
        last_w     = last_r;
        cmd_idx_w  = cmd_idx_r;
        retry_w    = retry_r;
        cool_w     = cool_r;
        sif.load   = 1'b0;
        sif.shift  = 1'b0;

        case (state_r)
            IDLE: begin
                if (i_start) begin
                    state_w   = START;
                    cmd_idx_w = '0;
                    retry_w   = '0;
                end
            end
            START: begin
                if (i_tick) begin
                    if (sda_r) begin  // sda falls under high scl
                        sda_w    = 1'b0;
                        sif.load = 1'b1;
                    end else begin
                        scl_w   = 1'b0;
                        sda_w   = sif.sda_bit;
                        state_w = DATA;
                    end
                end
            end
            DATA: begin
                if (i_tick) begin
                    scl_w = ~scl_r;
                    if (!scl_r) begin  // bit is on the wire, move shifter ahead
                        last_w    = sif.byte_end;
                        sif.shift = ~sif.byte_end;
                    end else if (last_r) begin
                        oe_w    = 1'b0;  // release for slave ack
                        state_w = ACK;
                    end else begin
                        sda_w = sif.sda_bit;
                    end
                end
            end
            ACK: begin
                if (i_tick) begin
                    scl_w = ~scl_r;
                    if (!scl_r) begin
                        last_w    = sif.frame_end;
                        sif.shift = ~sif.frame_end;
                    end else begin
                        oe_w = 1'b1;
                        if (sda_sync_r[1]) begin  // nack
                            retry_w = retry_r + 1'b1;
                            sda_w   = 1'b0;
                            state_w = STOP;
                        end else if (last_r) begin
                            retry_w = '0;
                            sda_w   = 1'b0;
                            state_w = STOP;
                        end else begin
                            sda_w   = sif.sda_bit;
                            state_w = DATA;
                        end
                    end
                end
            end
            STOP: begin
                if (i_tick) begin
                    if (!scl_r) begin
                        scl_w = 1'b1;
                    end else begin
                        sda_w = 1'b1;  // sda rises under high scl
                        if (retry_r == RETRY_W'(MAX_RETRY)) begin
                            error_w = 1'b1;
                            state_w = COOLDOWN;
                        end else if (retry_r != '0) begin
                            state_w = START;  // resend same index
                        end else if (cmd_idx_r == CMD_IDX_W'(N_CMDS - 1)) begin
                            finished_w = 1'b1;
                            state_w    = COOLDOWN;
                        end else begin
                            cmd_idx_w = cmd_idx_r + 1'b1;
                            state_w   = START;
                        end
                    end
                end
            end
            COOLDOWN: begin
                if (i_tick) begin
                    if (cool_r == COOL_W'(COOLDOWN_TICKS - 1)) begin
                        cool_w  = '0;
                        state_w = IDLE;
                    end else begin
                        cool_w = cool_r + 1'b1;
                    end
                end
            end
            default: begin
                state_w = IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r    <= IDLE;
            scl_r      <= 1'b1;
            sda_r      <= 1'b1;
            oe_r       <= 1'b1;
            finished_r <= 1'b0;
            error_r    <= 1'b0;
            last_r     <= 1'b0;
            cmd_idx_r  <= '0;
            retry_r    <= '0;
            cool_r     <= '0;
            sda_sync_r <= 2'b11;  // line idles high
        end else begin
            state_r    <= state_w;
            scl_r      <= scl_w;
            sda_r      <= sda_w;
            oe_r       <= oe_w;
            finished_r <= finished_w;
            error_r    <= error_w;
            last_r     <= last_w;
            cmd_idx_r  <= cmd_idx_w;
            retry_r    <= retry_w;
            cool_r     <= cool_w;
            sda_sync_r <= {sda_sync_r[0], i_sda};
        end
    end

endmodule

// ==== scl_tick_gen.sv ====
`timescale 1ns/10ps

module scl_tick_gen #(
    parameter int CLK_DIV = 125
) (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_en,
    output logic o_tick
);

    localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLK_DIV - 1);

    logic [CNT_W-1:0] cnt_r;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt_r <= '0;
        end else if (!i_en || cnt_r == CNT_LAST) begin
            cnt_r <= '0;  // idle hold keeps first phase full length
        end else begin
            cnt_r <= cnt_r + 1'b1;
        end
    end

    assign o_tick = i_en && (cnt_r == CNT_LAST);

endmodule

// ==== shift_if.sv ====
`timescale 1ns/10ps

interface shift_if;
    import codec_cfg_pkg::*;

    logic       load;       // capture frame, clear bit count
    cfg_frame_t frame;      // word for the current cmd_idx
    logic       shift;      // advance to next bit
    logic       sda_bit;    // current bit, msb first
    logic       byte_end;   // current bit is last of its byte
    logic       frame_end;  // current bit is last of the frame

    modport ctrl (
        output load,
        output frame,
        output shift,
        input  sda_bit,
        input  byte_end,
        input  frame_end
    );

    modport shifter (
        input  load,
        input  frame,
        input  shift,
        output sda_bit,
        output byte_end,
        output frame_end
    );

endinterface

// ==== src.f ====
codec_cfg_pkg.sv
shift_if.sv
cfg_table.sv
scl_tick_gen.sv
frame_shifter.sv
init_ctrl.sv
codec_init_top.sv
tb_clk_gen.sv
tb_i2c_slave.sv
codec_init_tb.sv

// ==== tb_clk_gen.sv ====
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 3
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b1;  // release on a falling edge
    end

endmodule

// ==== tb_i2c_slave.sv ====
`timescale 1ns/10ps

module tb_i2c_slave (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_scl,
    input  logic        i_sda_m,
    input  logic        i_sda_oe,
    input  logic [6:0]  i_nack_reg,
    input  logic [7:0]  i_nack_count,
    output logic        o_sda_line,
    output logic        o_frame_valid,
    output logic [23:0] o_frame,
    output int          o_err_cnt
);

    logic        pull_r = 1'b1;      // 0 pulls the line low
    logic        prev_scl_r = 1'b1;
    logic        prev_sda_r = 1'b1;
    logic        in_frame_r;
    logic        nacked_r;           // this attempt was refused
    logic [3:0]  bit_cnt_r;          // 0..7 data, 8 ack due, 9 ack seen
    logic [1:0]  byte_idx_r;
    logic [23:0] shreg_r;
    logic [7:0]  nacks_given_r;
    logic        nack_now;

    // open drain line, master value only while it drives
    assign o_sda_line = i_sda_oe ? i_sda_m : pull_r;

    // refuse the register byte of the selected command
    assign nack_now = (byte_idx_r == 2'd1) && (shreg_r[7:1] == i_nack_reg)
                   && (nacks_given_r < i_nack_count);

    task automatic protocol_fail(input string what);
        o_err_cnt = o_err_cnt + 1;
        $display("protocol error at %0t: %s", $time, what);
    endtask

    always @(negedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pull_r        <= 1'b1;
            prev_scl_r    <= 1'b1;
            prev_sda_r    <= 1'b1;
            in_frame_r    <= 1'b0;
            nacked_r      <= 1'b0;
            bit_cnt_r     <= 4'd0;
            byte_idx_r    <= 2'd0;
            shreg_r       <= 24'd0;
            nacks_given_r <= 8'd0;
            o_frame_valid <= 1'b0;
            o_frame       <= 24'd0;
            o_err_cnt = 0;
        end else begin
            o_frame_valid <= 1'b0;
            if (!i_sda_oe && !(in_frame_r && bit_cnt_r >= 4'd8)) begin
                protocol_fail("master released SDA outside an acknowledge bit");
            end
            if (prev_scl_r && i_scl && prev_sda_r && !o_sda_line) begin
                if (in_frame_r) begin
                    protocol_fail("START inside an open frame");
                end
                in_frame_r <= 1'b1;
                nacked_r   <= 1'b0;
                bit_cnt_r  <= 4'd0;
                byte_idx_r <= 2'd0;
            end else if (prev_scl_r && i_scl && !prev_sda_r && o_sda_line) begin
                if (in_frame_r && byte_idx_r == 2'd3) begin
                    o_frame_valid <= 1'b1;
                    o_frame       <= shreg_r;
                    nacks_given_r <= 8'd0;
                end else if (!nacked_r) begin
                    protocol_fail("STOP before the frame was complete");
                end
                in_frame_r <= 1'b0;  // refused attempt is dropped here
            end else if (in_frame_r && !prev_scl_r && i_scl && !nacked_r
                         && byte_idx_r != 2'd3) begin
                if (bit_cnt_r < 4'd8) begin
                    shreg_r   <= {shreg_r[22:0], o_sda_line};
                    bit_cnt_r <= bit_cnt_r + 4'd1;
                end else begin
                    if (i_sda_oe) begin
                        protocol_fail("master drove SDA in the acknowledge bit");
                    end
                    nacked_r   <= o_sda_line;
                    byte_idx_r <= byte_idx_r + 2'd1;
                    bit_cnt_r  <= 4'd9;
                end
            end else if (in_frame_r && prev_scl_r && !i_scl) begin
                if (bit_cnt_r == 4'd8) begin
                    pull_r <= nack_now;  // released line reads as nack
                    if (nack_now) begin
                        nacks_given_r <= nacks_given_r + 8'd1;
                    end
                end else begin
                    pull_r <= 1'b1;
                    if (bit_cnt_r == 4'd9) begin
                        bit_cnt_r <= 4'd0;
                    end
                end
            end
            prev_scl_r <= i_scl;
            prev_sda_r <= o_sda_line;
        end
    end

endmodule
